//--- logic/core_pkg.sv
// Shared types for the three-stage RV32I subset core
// Word and field widths, opcodes, reset pc, stage structs
package core_pkg;

  // Widths fixed by the ISA
  typedef logic [31:0] word_t;    // Data and address word
  typedef logic [31:0] inst_t;    // Raw instruction
  typedef logic [4:0]  reg_id_t;  // Register index
  typedef logic [6:0]  opcode_t;  // Major opcode field

  // Major opcodes of the supported instructions
  localparam opcode_t OP_IMM    = 7'b0010011;  // addi
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;  // ebreak

  localparam logic [11:0] FUNCT12_EBREAK = 12'd1;

  localparam word_t RESET_PC = 32'h0000_0000;  // First fetch address
  localparam int    NUM_REGS = 32;

  // Decoder flag bundle
  typedef struct packed {
    logic need_imm;      // Second ALU operand is the immediate
    logic alu_add;       // addi or auipc
    logic is_ebreak;
    logic is_auipc;
    logic is_jal;
    logic inst_not_ipl;  // Anything outside the supported four
  } dec_ctrl_t;

  // IF/ID register
  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_t inst;
  } if_id_t;

  // ID/EX register
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_id_t   rd;
    word_t     rs1_val;  // Already includes write-through
    word_t     imm;
    dec_ctrl_t ctrl;
  } id_ex_t;

  // Retire record, one per executed instruction
  typedef struct packed {
    logic    valid;
    word_t   pc;
    reg_id_t rd;    // Zero when nothing is written
    word_t   data;  // Written value, zero when nothing is written
  } commit_t;

endpackage

//--- logic/decoder.sv
// Instruction decoder for addi, auipc, jal and ebreak
// Field extraction, immediate select, control flags
`timescale 1ns/1ps

module decoder import core_pkg::*; (
  input  inst_t     inst,
  output reg_id_t   rd,
  output reg_id_t   rs1,
  output reg_id_t   rs2,
  output word_t     imm,
  output dec_ctrl_t ctrl
);

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct12 = inst[31:20];  // Only meaningful for SYSTEM

  // Opcode matches
  logic op_imm, op_auipc, op_jal, op_system;
  assign op_imm    = (opcode == OP_IMM);
  assign op_auipc  = (opcode == OP_AUIPC);
  assign op_jal    = (opcode == OP_JAL);
  assign op_system = (opcode == OP_SYSTEM);

  logic funct3_000;
  assign funct3_000 = (funct3 == 3'b000);

  // Recognised instructions
  logic addi, auipc, jal, ebreak;
  assign addi   = op_imm & funct3_000;
  assign auipc  = op_auipc;
  assign jal    = op_jal;
  assign ebreak = op_system & funct3_000 & (funct12 == FUNCT12_EBREAK);

  // Immediates per format, sign extended where the ISA says so
  word_t imm_i, imm_u, imm_j;
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // One-hot select by format, zero otherwise
  assign imm = ({32{addi}}  & imm_i) |
               ({32{auipc}} & imm_u) |
               ({32{jal}}   & imm_j);

  // Register fields straight from the encoding
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // Control flags
  assign ctrl.need_imm     = addi | auipc;
  assign ctrl.alu_add      = addi | auipc;
  assign ctrl.is_ebreak    = ebreak;
  assign ctrl.is_auipc     = auipc;
  assign ctrl.is_jal       = jal;
  assign ctrl.inst_not_ipl = ~(addi | auipc | jal | ebreak);  // Traps in EX

endmodule

//--- logic/reg_file.sv
// Integer register file, 32 x 32
// One write-through read port, x0 reads zero
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  reg_id_t rs1,
  output word_t   rs1_val,
  input  logic    wb_en,
  input  reg_id_t wb_rd,
  input  word_t   wb_data
);

  word_t regs [NUM_REGS];

  // Synchronous write, x0 never stored
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Read sees a same-cycle write
  always_comb begin
    if (rs1 == '0) begin
      rs1_val = '0;  // Hard-wired zero
    end else if (wb_en && (wb_rd == rs1)) begin
      rs1_val = wb_data;  // Bypass, no stall needed
    end else begin
      rs1_val = regs[rs1];
    end
  end

endmodule

//--- logic/fetch_stage.sv
// Fetch stage
// PC register, redirect and halt handling, IF/ID register
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   redirect,
  input  word_t  redirect_pc,
  input  logic   halted,
  output word_t  imem_addr,
  input  inst_t  imem_data,
  output if_id_t if_id
);

  word_t pc;
  word_t pc_next;

  assign imem_addr = pc;  // Memory answers in the same cycle

  // Next pc priority: redirect, then halt freeze, then sequential
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (halted) begin
      pc_next = pc;  // Frozen until reset
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= RESET_PC;
      if_id.valid <= 1'b0;
    end else begin
      pc <= pc_next;
      // Younger fetch squashed on jal or halt
      if_id.valid <= ~redirect & ~halted;
      if_id.pc    <= pc;
      if_id.inst  <= imem_data;
    end
  end

endmodule

//--- logic/decode_stage.sv
// Decode stage
// Decoder and register read, ID/EX register with flush
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  if_id_t  if_id,
  input  logic    flush,
  input  logic    wb_en,
  input  reg_id_t wb_rd,
  input  word_t   wb_data,
  output id_ex_t  id_ex
);

  reg_id_t   rd;
  reg_id_t   rs1;
  word_t     imm;
  dec_ctrl_t ctrl;
  word_t     rs1_val;

  decoder u_decoder (
    .inst (if_id.inst),
    .rd   (rd),
    .rs1  (rs1),
    .rs2  (),  // No reg-reg ops, single read port
    .imm  (imm),
    .ctrl (ctrl)
  );

  // Writeback comes straight from EX
  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs1_val (rs1_val),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid   <= if_id.valid & ~flush;  // Bubble on jal or halt
      id_ex.pc      <= if_id.pc;
      id_ex.rd      <= rd;
      id_ex.rs1_val <= rs1_val;
      id_ex.imm     <= imm;
      id_ex.ctrl    <= ctrl;
    end
  end

endmodule

//--- logic/execute_stage.sv
// Execute stage
// ALU add, jal link and target, writeback, redirect, halt and trap
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  id_ex_t  id_ex,
  output logic    wb_en,
  output reg_id_t wb_rd,
  output word_t   wb_data,
  output logic    redirect,
  output word_t   redirect_pc,
  output logic    halted,
  output logic    trap,
  output commit_t commit
);

  logic  ex_valid;
  logic  writes_rd;
  logic  stop;
  word_t alu_a, alu_b, alu_sum;
  word_t link;
  word_t result;

  // Entry that followed a halting instruction is dropped
  assign ex_valid = id_ex.valid & ~halted;

  // Adder, pc operand only for auipc
  assign alu_a   = id_ex.ctrl.is_auipc ? id_ex.pc : id_ex.rs1_val;
  assign alu_b   = id_ex.ctrl.need_imm ? id_ex.imm : '0;
  assign alu_sum = alu_a + alu_b;

  assign link   = id_ex.pc + 32'd4;
  assign result = id_ex.ctrl.is_jal ? link : alu_sum;

  // addi, auipc and jal are the only writers
  assign writes_rd = id_ex.ctrl.alu_add | id_ex.ctrl.is_jal;

  assign wb_en   = ex_valid & writes_rd & (id_ex.rd != '0);
  assign wb_rd   = id_ex.rd;
  assign wb_data = result;

  // jal redirects in the same cycle
  assign redirect    = ex_valid & id_ex.ctrl.is_jal;
  assign redirect_pc = id_ex.pc + id_ex.imm;

  assign stop = ex_valid & (id_ex.ctrl.is_ebreak | id_ex.ctrl.inst_not_ipl);

  // Halt is sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
      trap   <= 1'b0;
    end else if (stop) begin
      halted <= 1'b1;
      trap   <= id_ex.ctrl.inst_not_ipl;  // Low for ebreak
    end
  end

  // Retire record, ebreak and traps carry no write
  assign commit.valid = ex_valid;
  assign commit.pc    = id_ex.pc;
  assign commit.rd    = writes_rd ? id_ex.rd : '0;
  assign commit.data  = writes_rd ? result : '0;

endmodule

//--- logic/core_top.sv
// Core top level
// Fetch, decode and execute stages, instruction port, retire port
`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  output word_t   imem_addr,
  input  inst_t   imem_data,
  output commit_t commit,
  output logic    halted,
  output logic    trap
);

  if_id_t  if_id;
  id_ex_t  id_ex;
  logic    wb_en;
  reg_id_t wb_rd;
  word_t   wb_data;
  logic    redirect;
  word_t   redirect_pc;
  logic    flush;

  assign flush = redirect | halted;  // Squash the decode slot

  fetch_stage u_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (halted),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .if_id       (if_id)
  );

  decode_stage u_decode (
    .clk     (clk),
    .rst     (rst),
    .if_id   (if_id),
    .flush   (flush),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .id_ex   (id_ex)
  );

  execute_stage u_execute (
    .clk         (clk),
    .rst         (rst),
    .id_ex       (id_ex),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (halted),
    .trap        (trap),
    .commit      (commit)
  );

endmodule

//--- bench/tb_core.sv
// Testbench for the three-stage core
// Program loader, in-order reference model, commit checks, watchdog
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

  localparam inst_t EBREAK_WORD = 32'h0010_0073;
  localparam inst_t ADD_WORD    = 32'h0020_81b3;  // add x3, x1, x2 (not implemented)

  logic    clk = 1'b0;
  logic    rst;
  word_t   imem_addr;
  inst_t   imem_data;
  commit_t commit;
  logic    halted;
  logic    trap;

  inst_t   imem [0:63];       // 256 bytes from address 0
  inst_t   prog [$];          // Program being assembled
  commit_t exp_rec [0:255];   // Expected retire records in order
  commit_t exp_head;
  logic [7:0] exp_len;
  logic [7:0] exp_idx;        // Next record to retire
  logic    exp_trap;
  word_t   lfsr = 32'h8b757a35;
  string   test_name = "none";
  int      budget = 10;       // Startup slack
  int      check_errors = 0;
  int      end_errors = 0;
  int      tests_run = 0;
  int      tests_failed = 0;

  core_top DUT (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .commit    (commit),
    .halted    (halted),
    .trap      (trap)
  );

  always #5 clk = ~clk;

  // Unused words decode as reg-reg ops so a runaway fetch traps
  function automatic inst_t fill_word(input word_t addr);
    return {addr[31:7] ^ addr[24:0], 7'b0110011};
  endfunction

  function automatic inst_t mem_word(input word_t addr);
    if (addr[31:8] == '0) return imem[addr[7:2]];
    return fill_word(addr);
  endfunction

  // Combinational instruction port
  always_comb begin
    if (imem_addr[31:8] == '0) imem_data = imem[imem_addr[7:2]];
    else imem_data = fill_word(imem_addr);
  end

  // Galois LFSR stepped once per bit taken
  function automatic word_t take_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Encodings as the ISA defines them
  function automatic inst_t addi_word(input reg_id_t rd, input reg_id_t rs1, input word_t imm);
    return {imm[11:0], rs1, 3'b000, rd, OP_IMM};
  endfunction

  function automatic inst_t auipc_word(input reg_id_t rd, input word_t imm);
    return {imm[19:0], rd, OP_AUIPC};
  endfunction

  function automatic inst_t jal_word(input reg_id_t rd, input word_t off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  // In-order ISA model filling exp_rec up to the stopping instruction
  function automatic void build_expected();
    word_t   rf [32];
    word_t   pc;
    word_t   pc_next;
    inst_t   w;
    commit_t rec;
    logic    stop;
    for (int i = 0; i < 32; i++) rf[i] = '0;
    pc      = RESET_PC;
    stop    = 1'b0;
    exp_len = '0;
    while (!stop && exp_len < 8'd200) begin
      w         = mem_word(pc);
      rec.valid = 1'b1;
      rec.pc    = pc;
      rec.rd    = '0;
      rec.data  = '0;
      pc_next   = pc + 32'd4;
      if (w[6:0] == OP_IMM && w[14:12] == 3'b000) begin
        rec.rd   = w[11:7];
        rec.data = rf[w[19:15]] + {{20{w[31]}}, w[31:20]};
      end else if (w[6:0] == OP_AUIPC) begin
        rec.rd   = w[11:7];
        rec.data = pc + {w[31:12], 12'b0};
      end else if (w[6:0] == OP_JAL) begin
        rec.rd   = w[11:7];
        rec.data = pc + 32'd4;  // Link
        pc_next  = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end else begin
        stop     = 1'b1;
        exp_trap = (w != EBREAK_WORD);
      end
      if (rec.rd != '0) rf[rec.rd] = rec.data;  // x0 stays zero
      exp_rec[exp_len] = rec;
      exp_len = exp_len + 8'd1;
      pc = pc_next;
    end
  endfunction

  // Retire pointer advances on every commit
  always @(posedge clk) begin
    if (rst) exp_idx <= '0;
    else if (commit.valid) exp_idx <= exp_idx + 8'd1;
  end

  assign exp_head = exp_rec[exp_idx];

  commit_check: assert property (@(negedge clk) disable iff (rst)
    commit.valid |-> (exp_idx < exp_len) && (commit == exp_head))
  else begin
    check_errors++;
    if (exp_idx >= exp_len)
      $display("unexpected commit in %s at pc %h after the last expected one",
               test_name, commit.pc);
    else
      $display("FAIL %s: expected pc %h rd %0d data %h, actual pc %h rd %0d data %h",
               test_name, exp_head.pc, exp_head.rd, exp_head.data,
               commit.pc, commit.rd, commit.data);
  end

  // Halt and trap rise at the edge that retires the stopping instruction
  halt_check: assert property (@(negedge clk) disable iff (rst)
    (halted == (exp_idx == exp_len)) && (trap == ((exp_idx == exp_len) & exp_trap)))
  else begin
    check_errors++;
    $display("FAIL %s: expected halted %b trap %b, actual halted %b trap %b",
             test_name, (exp_idx == exp_len), ((exp_idx == exp_len) & exp_trap),
             halted, trap);
  end

  // Load, reset, run to halt, run out 20 cycles, check the end state
  task automatic run_program(input string name);
    int err_before;
    err_before = check_errors + end_errors;
    test_name  = name;
    @(posedge clk);
    #1 rst = 1'b1;
    for (int i = 0; i < 64; i++) imem[6'(i)] = fill_word(word_t'(i * 4));
    foreach (prog[i]) imem[6'(i)] = prog[i];
    budget += 2 * prog.size() + 30;
    build_expected();
    prog.delete();
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    do @(negedge clk); while (!halted);
    repeat (20) @(negedge clk);  // Nothing may retire now
    assert (exp_idx == exp_len) else begin
      end_errors++;
      $display("FAIL %s: expected %0d commits actual %0d", name, exp_len, exp_idx);
    end
    tests_run++;
    if (check_errors + end_errors == err_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed", name);
    end
  endtask

  task automatic addi_chain_test();
    reg_id_t rs;
    rs = '0;
    for (int k = 0; k < 12; k++) begin
      prog.push_back(addi_word(5'(k + 1), rs, take_bits(12)));  // Reads previous rd
      rs = 5'(k + 1);
    end
    prog.push_back(EBREAK_WORD);
    run_program("addi_chain");
  endtask

  task automatic auipc_test();
    for (int k = 0; k < 6; k++) begin
      prog.push_back(auipc_word(5'(k + 1), take_bits(20)));
      if (k[0]) prog.push_back(addi_word(5'd0, 5'd0, '0));  // Shifts later addresses
    end
    prog.push_back(EBREAK_WORD);
    run_program("auipc");
  endtask

  task automatic jal_test();
    prog.push_back(addi_word(5'd1, 5'd0, take_bits(12)));  // 0
    prog.push_back(jal_word(5'd5, 32'd12));                 // 4 to 16
    prog.push_back(ADD_WORD);                               // Squashed
    prog.push_back(ADD_WORD);                               // Squashed
    prog.push_back(addi_word(5'd6, 5'd5, '0));              // 16 reads link
    prog.push_back(jal_word(5'd7, 32'd20));                 // 20 to 40
    repeat (4) prog.push_back(ADD_WORD);
    prog.push_back(auipc_word(5'd8, take_bits(20)));        // 40
    prog.push_back(EBREAK_WORD);
    run_program("jal");
  endtask

  task automatic x0_test();
    prog.push_back(addi_word(5'd0, 5'd0, take_bits(12)));
    prog.push_back(addi_word(5'd9, 5'd0, take_bits(12)));   // Right after x0 write
    prog.push_back(jal_word(5'd0, 32'd8));
    prog.push_back(ADD_WORD);
    prog.push_back(addi_word(5'd10, 5'd0, take_bits(12)));
    prog.push_back(EBREAK_WORD);
    run_program("x0_writes");
  endtask

  task automatic ebreak_test();
    prog.push_back(addi_word(5'd1, 5'd0, take_bits(12)));
    prog.push_back(EBREAK_WORD);
    prog.push_back(addi_word(5'd2, 5'd1, take_bits(12)));   // Must never retire
    prog.push_back(addi_word(5'd3, 5'd2, take_bits(12)));
    run_program("ebreak");
  endtask

  task automatic unimpl_test();
    prog.push_back(addi_word(5'd1, 5'd0, take_bits(12)));
    prog.push_back(addi_word(5'd2, 5'd1, take_bits(12)));
    prog.push_back(ADD_WORD);                               // Traps
    prog.push_back(addi_word(5'd4, 5'd1, take_bits(12)));
    prog.push_back(EBREAK_WORD);
    run_program("unimplemented");
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= budget) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the core did not halt in time", cycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst = 1'b1;
    for (int i = 0; i < 64; i++) imem[6'(i)] = fill_word(word_t'(i * 4));
    addi_chain_test();
    auipc_test();
    jal_test();
    x0_test();
    ebreak_test();
    unimpl_test();
    $display("tests %0d, failed %0d, commit errors %0d, end-state errors %0d",
             tests_run, tests_failed, check_errors, end_errors);
    if (check_errors + end_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- filelist.f
logic/core_pkg.sv
logic/decoder.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/core_top.sv
bench/tb_core.sv

//--- Makefile
# Verilator build and run for the core testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_core
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Shows the simulation output and fails unless the pass line is in it
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
